//--- source/regMachine_macros.svh
`ifndef REG_MACHINE_MACROS_SVH
`define REG_MACHINE_MACROS_SVH

// register and data path width
`define DATA_WIDTH 8

// registers in the file, paired as even/odd
`define REG_COUNT 16
`define REG_IDX_W 4

`endif

//--- source/regMachinePkg.sv
`default_nettype none

`include "regMachine_macros.svh"

package regMachinePkg;

    // host command codes
    typedef enum logic [3:0] {
        OP_LDI    = 4'd0,
        OP_MOV    = 4'd1,
        OP_ADD    = 4'd2,
        OP_SUB    = 4'd3,
        OP_AND    = 4'd4,
        OP_XOR    = 4'd5,
        OP_INCP   = 4'd6,
        OP_DECP   = 4'd7,
        OP_RDH    = 4'd8,
        OP_LDIINC = 4'd9
    } opcode_t;

    // operations of the ALU, A is the destination register
    typedef enum logic [2:0] {
        ALU_PASSB = 3'd0,
        ALU_ADD   = 3'd1,
        ALU_SUB   = 3'd2,
        ALU_AND   = 3'd3,
        ALU_XOR   = 3'd4
    } aluOp_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] value;
        // carry out for add, borrow for sub
        logic                   carry;
        logic                   zero;
    } aluResult_t;

endpackage

`default_nettype wire

//--- source/regBus.sv
`default_nettype none

`include "regMachine_macros.svh"

interface regBus;

    // selects and write controls from the sequencer
    logic [`REG_IDX_W-1:0]  aSel;
    logic [`REG_IDX_W-1:0]  bSel;
    logic [`DATA_WIDTH-1:0] writeData;
    logic                   writeEn;
    logic                   inc;
    logic                   dec;

    // read data from the register file
    logic [`DATA_WIDTH-1:0] outA;
    logic [`DATA_WIDTH-1:0] outB;
    logic [`DATA_WIDTH-1:0] pairHigh;

    modport sequencer (
        output aSel, bSel, writeData, writeEn, inc, dec,
        input  outA, outB, pairHigh
    );

    modport storage (
        input  aSel, bSel, writeData, writeEn, inc, dec,
        output outA, outB, pairHigh
    );

    modport alu (
        input outA, outB
    );

endinterface

`default_nettype wire

//--- source/regFile.sv
`default_nettype none

`include "regMachine_macros.svh"

module regFile (
    input logic    clk,
    input logic    rstN,
    regBus.storage rb
);

    localparam logic [2*`DATA_WIDTH-1:0] pairOne = 1;

    logic [`DATA_WIDTH-1:0]   regs [`REG_COUNT];
    logic [`REG_IDX_W-1:0]    pairLo;
    logic [`REG_IDX_W-1:0]    pairHi;
    logic                     pairEven;
    logic [2*`DATA_WIDTH-1:0] pairValue;
    logic [2*`DATA_WIDTH-1:0] pairNext;
    logic                     stepEn;

    // pair is {r[bSel+1], r[bSel]}, only valid for an even bSel
    assign pairLo    = {rb.bSel[`REG_IDX_W-1:1], 1'b0};
    assign pairHi    = {rb.bSel[`REG_IDX_W-1:1], 1'b1};
    assign pairEven  = ~rb.bSel[0];
    assign pairValue = {regs[pairHi], regs[pairLo]};

    always_comb begin
        if (rb.inc) begin
            pairNext = pairValue + pairOne;
        end else if (rb.dec) begin
            pairNext = pairValue - pairOne;
        end else begin
            pairNext = pairValue;
        end
    end

    // a byte write onto the low register cancels the step
    assign stepEn = (rb.inc || rb.dec) && pairEven &&
                    !(rb.writeEn && (rb.aSel == pairLo));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (rb.writeEn) begin
                regs[rb.aSel] <= rb.writeData;
            end
            // issued after the write so the step owns the high byte on a clash
            if (stepEn) begin
                regs[pairLo] <= pairNext[`DATA_WIDTH-1:0];
                regs[pairHi] <= pairNext[2*`DATA_WIDTH-1:`DATA_WIDTH];
            end
        end
    end

    // combinational read ports
    assign rb.outA = regs[rb.aSel];
    assign rb.outB = regs[rb.bSel];

    always_comb begin
        if (pairEven) begin
            rb.pairHigh = regs[pairHi];
        end else begin
            rb.pairHigh = '0;
        end
    end

    // the sequencer decodes at most one pair step per command
    incDecExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(rb.inc && rb.dec)
    ) else $error("regFile: inc and dec high together");

endmodule

`default_nettype wire

//--- source/aluUnit.sv
`default_nettype none

`include "regMachine_macros.svh"

module aluUnit (
    regBus.alu                         rb,
    input  regMachinePkg::aluOp_t      aluOp,
    output regMachinePkg::aluResult_t  result
);

    import regMachinePkg::*;

    // one extra bit catches carry out or borrow
    logic [`DATA_WIDTH:0] full;

    always_comb begin
        case (aluOp)
            ALU_PASSB: begin
                full = {1'b0, rb.outB};
            end
            ALU_ADD: begin
                full = {1'b0, rb.outA} + {1'b0, rb.outB};
            end
            ALU_SUB: begin
                // top bit set when outB is larger than outA
                full = {1'b0, rb.outA} - {1'b0, rb.outB};
            end
            ALU_AND: begin
                full = {1'b0, rb.outA & rb.outB};
            end
            ALU_XOR: begin
                full = {1'b0, rb.outA ^ rb.outB};
            end
            default: begin
                full = '0;
            end
        endcase
    end

    always_comb begin
        result.value = full[`DATA_WIDTH-1:0];
        result.carry = full[`DATA_WIDTH];
        result.zero  = (full[`DATA_WIDTH-1:0] == '0);
    end

endmodule

`default_nettype wire

//--- source/cmdSequencer.sv
`default_nettype none

`include "regMachine_macros.svh"

module cmdSequencer (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       cmdReq,
    input  regMachinePkg::opcode_t     cmdOp,
    input  logic [`REG_IDX_W-1:0]      cmdDst,
    input  logic [`REG_IDX_W-1:0]      cmdSrc,
    input  logic [`DATA_WIDTH-1:0]     cmdImm,
    output logic                       cmdAck,
    output logic [`DATA_WIDTH-1:0]     resultData,
    output logic                       resultCarry,
    output logic                       resultZero,
    regBus.sequencer                   rb,
    output regMachinePkg::aluOp_t      aluOp,
    input  regMachinePkg::aluResult_t  aluResult
);

    import regMachinePkg::*;

    typedef enum logic {
        S_IDLE,
        S_HELD
    } state_t;

    state_t                 state;
    logic                   fire;
    logic                   writeReq;
    logic                   incReq;
    logic                   decReq;
    logic                   useImm;
    logic [`DATA_WIDTH-1:0] nextData;
    logic                   nextCarry;
    logic                   nextZero;

    // a command executes only on the edge that moves idle to held
    assign fire = (state == S_IDLE) && cmdReq;

    always_comb begin
        aluOp     = ALU_PASSB;
        writeReq  = 1'b0;
        incReq    = 1'b0;
        decReq    = 1'b0;
        useImm    = 1'b0;
        nextData  = aluResult.value;
        nextCarry = 1'b0;
        case (cmdOp)
            OP_LDI: begin
                writeReq = 1'b1;
                useImm   = 1'b1;
                nextData = cmdImm;
            end
            OP_MOV: begin
                writeReq = 1'b1;
            end
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                writeReq  = 1'b1;
                nextCarry = aluResult.carry;
                if (cmdOp == OP_ADD) begin
                    aluOp = ALU_ADD;
                end else if (cmdOp == OP_SUB) begin
                    aluOp = ALU_SUB;
                end else if (cmdOp == OP_AND) begin
                    aluOp = ALU_AND;
                end else begin
                    aluOp = ALU_XOR;
                end
            end
            OP_INCP, OP_DECP: begin
                incReq   = (cmdOp == OP_INCP);
                decReq   = (cmdOp == OP_DECP);
                // old low byte of the pair
                nextData = rb.outB;
            end
            OP_RDH: begin
                nextData = rb.pairHigh;
            end
            OP_LDIINC: begin
                writeReq = 1'b1;
                incReq   = 1'b1;
                useImm   = 1'b1;
                nextData = cmdImm;
            end
            default: begin
                nextData = '0;
            end
        endcase
        // alu results bring their own zero flag
        nextZero = (writeReq && !useImm) ? aluResult.zero : (nextData == '0);
    end

    assign rb.aSel      = cmdDst;
    assign rb.bSel      = cmdSrc;
    assign rb.writeData = useImm ? cmdImm : aluResult.value;
    assign rb.writeEn   = fire && writeReq;
    assign rb.inc       = fire && incReq;
    assign rb.dec       = fire && decReq;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= S_IDLE;
            resultData  <= '0;
            resultCarry <= 1'b0;
            resultZero  <= 1'b0;
        end else if (fire) begin
            state       <= S_HELD;
            resultData  <= nextData;
            resultCarry <= nextCarry;
            resultZero  <= nextZero;
        end else if ((state == S_HELD) && !cmdReq) begin
            state <= S_IDLE;
        end
    end

    assign cmdAck = (state == S_HELD);

    // host must release the request before ack may drop
    ackHeldWithReq: assert property (
        @(posedge clk) disable iff (!rstN)
        (cmdAck && cmdReq) |=> cmdAck
    ) else $error("cmdSequencer: cmdAck fell while cmdReq high");

    opKnownOnReq: assert property (
        @(posedge clk) disable iff (!rstN)
        cmdReq |-> !$isunknown(cmdOp)
    ) else $error("cmdSequencer: cmdOp unknown during request");

endmodule

`default_nettype wire

//--- source/regMachine.sv
`default_nettype none

`include "regMachine_macros.svh"

module regMachine (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    cmdReq,
    input  regMachinePkg::opcode_t  cmdOp,
    input  logic [`REG_IDX_W-1:0]   cmdDst,
    input  logic [`REG_IDX_W-1:0]   cmdSrc,
    input  logic [`DATA_WIDTH-1:0]  cmdImm,
    output logic                    cmdAck,
    output logic [`DATA_WIDTH-1:0]  resultData,
    output logic                    resultCarry,
    output logic                    resultZero
);

    import regMachinePkg::*;

    aluOp_t     aluOp;
    aluResult_t aluResult;

    // shared select and read-data bus
    regBus rb ();

    regFile uRegFile (
        .clk  (clk),
        .rstN (rstN),
        .rb   (rb.storage)
    );

    aluUnit uAlu (
        .rb     (rb.alu),
        .aluOp  (aluOp),
        .result (aluResult)
    );

    cmdSequencer uSeq (
        .clk         (clk),
        .rstN        (rstN),
        .cmdReq      (cmdReq),
        .cmdOp       (cmdOp),
        .cmdDst      (cmdDst),
        .cmdSrc      (cmdSrc),
        .cmdImm      (cmdImm),
        .cmdAck      (cmdAck),
        .resultData  (resultData),
        .resultCarry (resultCarry),
        .resultZero  (resultZero),
        .rb          (rb.sequencer),
        .aluOp       (aluOp),
        .aluResult   (aluResult)
    );

endmodule

`default_nettype wire

//--- verif/regMachineTb.sv
`default_nettype none

module regMachineTb;

    import regMachinePkg::*;

    localparam int AckTimeout = 16;

    logic        clk;
    logic        rstN;
    logic        cmdReq;
    opcode_t     cmdOp;
    logic [3:0]  cmdDst;
    logic [3:0]  cmdSrc;
    logic [7:0]  cmdImm;
    logic        cmdAck;
    logic [7:0]  resultData;
    logic        resultCarry;
    logic        resultZero;

    logic [7:0]  shadowRegs [16];
    logic [7:0]  expData;
    logic        expCarry;
    logic        expZero;
    logic [31:0] lfsrState;
    int          errCount;
    int          errAtStart;
    int          testCount;
    int          testFails;
    bit          timedOut;

    regMachine DUT (
        .clk         (clk),
        .rstN        (rstN),
        .cmdReq      (cmdReq),
        .cmdOp       (cmdOp),
        .cmdDst      (cmdDst),
        .cmdSrc      (cmdSrc),
        .cmdImm      (cmdImm),
        .cmdAck      (cmdAck),
        .resultData  (resultData),
        .resultCarry (resultCarry),
        .resultZero  (resultZero)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    resetValues: assert property (
        @(posedge clk) !rstN |-> (!cmdAck && resultData == 8'h00 && !resultCarry && !resultZero)
    ) else begin
        errCount++;
        $display("[FAIL] reset cmdAck %h resultData %h resultCarry %h resultZero %h",
                 $sampled(cmdAck), $sampled(resultData), $sampled(resultCarry),
                 $sampled(resultZero));
    end

    // checked on every acknowledged cycle including held ones
    dataMatches: assert property (
        @(posedge clk) disable iff (!rstN) cmdAck |-> resultData == expData
    ) else begin
        errCount++;
        $display("[FAIL] resultData expected %h got %h", $sampled(expData), $sampled(resultData));
    end

    carryMatches: assert property (
        @(posedge clk) disable iff (!rstN) cmdAck |-> resultCarry == expCarry
    ) else begin
        errCount++;
        $display("[FAIL] resultCarry expected %h got %h", $sampled(expCarry),
                 $sampled(resultCarry));
    end

    zeroMatches: assert property (
        @(posedge clk) disable iff (!rstN) cmdAck |-> resultZero == expZero
    ) else begin
        errCount++;
        $display("[FAIL] resultZero expected %h got %h", $sampled(expZero), $sampled(resultZero));
    end

    ackRises: assert property (
        @(posedge clk) disable iff (!rstN) (cmdReq && !cmdAck) |=> cmdAck
    ) else begin
        errCount++;
        $display("cmdAck did not rise on the first edge with cmdReq high");
    end

    ackHolds: assert property (
        @(posedge clk) disable iff (!rstN) (cmdAck && cmdReq) |=> cmdAck
    ) else begin
        errCount++;
        $display("cmdAck fell while cmdReq was still high");
    end

    ackFalls: assert property (
        @(posedge clk) disable iff (!rstN) (cmdAck && !cmdReq) |=> !cmdAck
    ) else begin
        errCount++;
        $display("cmdAck did not fall on the first edge with cmdReq low");
    end

    ackIdle: assert property (
        @(posedge clk) disable iff (!rstN) (!cmdAck && !cmdReq) |=> !cmdAck
    ) else begin
        errCount++;
        $display("cmdAck rose without a request");
    end

    // galois lfsr stepped once per bit
    function automatic logic [7:0] takeBits(input int count);
        logic [7:0] bits;
        bits = 8'h00;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
            bits = {bits[6:0], lfsrState[0]};
        end
        return bits;
    endfunction

    function automatic logic [7:0] pickOperand(input int idx);
        case (idx)
            0: return 8'h00;
            1: return 8'hFF;
            2: return 8'h80;
            default: return takeBits(8);
        endcase
    endfunction

    // shadow register update and expected result of one command
    task automatic predict(input opcode_t op, input logic [3:0] d, input logic [3:0] s,
                           input logic [7:0] imm);
        logic [8:0]  wide;
        logic [15:0] pair;
        logic [3:0]  hi;
        hi = s | 4'd1;
        pair = {shadowRegs[hi], shadowRegs[s]};
        expCarry = 1'b0;
        case (op)
            OP_LDI, OP_LDIINC: begin
                expData = imm;
                shadowRegs[d] = imm;
                // step from the old pair so it owns the high byte when d is s+1
                if (op == OP_LDIINC && !s[0] && d != s) begin
                    pair = pair + 16'd1;
                    shadowRegs[s] = pair[7:0];
                    shadowRegs[hi] = pair[15:8];
                end
            end
            OP_MOV: begin
                expData = shadowRegs[s];
                shadowRegs[d] = expData;
            end
            OP_ADD: begin
                wide = {1'b0, shadowRegs[d]} + {1'b0, shadowRegs[s]};
                expData = wide[7:0];
                expCarry = wide[8];
                shadowRegs[d] = expData;
            end
            OP_SUB: begin
                expData = shadowRegs[d] - shadowRegs[s];
                expCarry = shadowRegs[d] < shadowRegs[s];
                shadowRegs[d] = expData;
            end
            OP_AND: begin
                expData = shadowRegs[d] & shadowRegs[s];
                shadowRegs[d] = expData;
            end
            OP_XOR: begin
                expData = shadowRegs[d] ^ shadowRegs[s];
                shadowRegs[d] = expData;
            end
            OP_INCP, OP_DECP: begin
                expData = shadowRegs[s];
                if (!s[0]) begin
                    pair = (op == OP_INCP) ? pair + 16'd1 : pair - 16'd1;
                    shadowRegs[s] = pair[7:0];
                    shadowRegs[hi] = pair[15:8];
                end
            end
            OP_RDH: begin
                expData = s[0] ? 8'h00 : shadowRegs[hi];
            end
            default: begin
                expData = 8'h00;
            end
        endcase
        expZero = (expData == 8'h00);
    endtask

    // one four-phase command with cmdReq held holdExtra cycles past ack
    task automatic issue(input opcode_t op, input logic [3:0] d, input logic [3:0] s,
                         input logic [7:0] imm, input int holdExtra);
        int waitCount;
        if (timedOut) begin
            return;
        end
        predict(op, d, s, imm);
        cmdOp = op;
        cmdDst = d;
        cmdSrc = s;
        cmdImm = imm;
        cmdReq = 1'b1;
        waitCount = 0;
        while (!cmdAck) begin
            @(posedge clk);
            #1;
            waitCount++;
            if (waitCount > AckTimeout) begin
                $display("cmdAck did not rise within %0d cycles of cmdReq", AckTimeout);
                timedOut = 1'b1;
                return;
            end
        end
        repeat (holdExtra) begin
            @(posedge clk);
            #1;
        end
        cmdReq = 1'b0;
        waitCount = 0;
        while (cmdAck) begin
            @(posedge clk);
            #1;
            waitCount++;
            if (waitCount > AckTimeout) begin
                $display("cmdAck did not fall within %0d cycles of cmdReq low", AckTimeout);
                timedOut = 1'b1;
                return;
            end
        end
        // one idle cycle before the next request
        @(posedge clk);
        #1;
    endtask

    task automatic readBack();
        for (int i = 0; i < 16; i++) begin
            issue(OP_MOV, 4'(i), 4'(i), 8'h00, 0);
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errCount != errAtStart || timedOut) begin
            testFails++;
            $display("test %0d %s: %0d errors", testCount, name, errCount - errAtStart);
        end else begin
            $display("test %0d %s: ok", testCount, name);
        end
        errAtStart = errCount;
    endtask

    initial begin
        logic [3:0] d;
        logic [3:0] s;
        logic [7:0] opSel;
        int         hold;
        opcode_t    aluCmds [4];
        aluCmds = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};
        lfsrState = 32'h289a_23c0;
        errCount = 0;
        errAtStart = 0;
        testCount = 0;
        testFails = 0;
        timedOut = 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadowRegs[i] = 8'h00;
        end
        expData = 8'h00;
        expCarry = 1'b0;
        expZero = 1'b0;
        rstN = 1'b1;
        cmdReq = 1'b0;
        cmdOp = OP_LDI;
        cmdDst = 4'd0;
        cmdSrc = 4'd0;
        cmdImm = 8'h00;
        #1 rstN = 1'b0;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;

        readBack();
        for (int i = 0; i < 16; i++) begin
            issue(OP_RDH, 4'd0, 4'(i), 8'h00, 0);
        end
        finishTest("reset state");

        for (int n = 0; n < 32; n++) begin
            opSel = takeBits(1);
            d = 4'(takeBits(4));
            s = 4'(takeBits(4));
            issue(opSel[0] ? OP_MOV : OP_LDI, d, s, takeBits(8), 0);
        end
        readBack();
        finishTest("load and move");

        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    d = 4'(takeBits(4));
                    s = d + 4'(takeBits(3)) + 4'd1;
                    issue(OP_LDI, d, 4'd0, pickOperand(i), 0);
                    issue(OP_LDI, s, 4'd0, pickOperand(j), 0);
                    issue(aluCmds[k], d, s, 8'h00, 0);
                end
            end
        end
        readBack();
        finishTest("alu operations");

        for (int p = 0; p < 16; p += 2) begin
            s = 4'(p);
            // 0x00FF steps to 0x0100
            issue(OP_LDI, s, 4'd0, 8'hFF, 0);
            issue(OP_LDI, s + 4'd1, 4'd0, 8'h00, 0);
            issue(OP_INCP, 4'd0, s, 8'h00, 0);
            issue(OP_MOV, s, s, 8'h00, 0);
            issue(OP_RDH, 4'd0, s, 8'h00, 0);
            // 0xFFFF wraps to 0x0000 and back
            issue(OP_LDI, s, 4'd0, 8'hFF, 0);
            issue(OP_LDI, s + 4'd1, 4'd0, 8'hFF, 0);
            issue(OP_INCP, 4'd0, s, 8'h00, 0);
            issue(OP_DECP, 4'd0, s, 8'h00, 0);
            issue(OP_RDH, 4'd0, s, 8'h00, 0);
            // odd select leaves the pair alone
            issue(OP_INCP, 4'd0, s + 4'd1, 8'h00, 0);
            issue(OP_DECP, 4'd0, s + 4'd1, 8'h00, 0);
            issue(OP_RDH, 4'd0, s + 4'd1, 8'h00, 0);
        end
        readBack();
        finishTest("pair steps");

        issue(OP_LDI, 4'd4, 4'd0, 8'hFF, 0);
        issue(OP_LDI, 4'd5, 4'd0, 8'h12, 0);
        issue(OP_LDIINC, 4'd9, 4'd4, takeBits(8), 0);
        issue(OP_LDI, 4'd6, 4'd0, 8'h7F, 0);
        issue(OP_LDI, 4'd7, 4'd0, 8'h01, 0);
        issue(OP_LDIINC, 4'd6, 4'd6, takeBits(8), 0);
        issue(OP_LDI, 4'd2, 4'd0, 8'hFF, 0);
        issue(OP_LDI, 4'd3, 4'd0, 8'h40, 0);
        issue(OP_LDIINC, 4'd3, 4'd2, takeBits(8), 0);
        readBack();
        finishTest("load with pair step");

        for (int n = 0; n < 8; n++) begin
            d = 4'(takeBits(4));
            s = 4'(takeBits(4));
            hold = int'(takeBits(3)) + 1;
            issue(n[0] ? OP_INCP : OP_ADD, d, s, 8'h00, hold);
        end
        readBack();
        finishTest("handshake hold");

        $display("%0d tests, %0d failed, %0d check errors", testCount, testFails, errCount);
        if (errCount == 0 && testFails == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- regMachine.f
+incdir+source
source/regMachinePkg.sv
source/regBus.sv
source/regFile.sv
source/aluUnit.sv
source/cmdSequencer.sv
source/regMachine.sv
verif/regMachineTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f regMachine.f --top-module regMachineTb -o simRegMachine

out=$(./obj_dir/simRegMachine)
echo "$out"
echo "$out" | grep -q "Everything OK"
